/* dv/executeStageTb.sv */
`default_nettype none

module executeStageTb;
    import exPkg::*;

    localparam int numVectors     = 25;
    localparam int wordsPerVector = 20;
    localparam int resetCycles    = 16;
    localparam int cycleLimit     = numVectors + 40;

    logic       clk;
    logic       rstN;
    issueSlotT  issue1;
    issueSlotT  issue2;
    fwdBusT     fwd;
    laneResultT lane1;
    laneResultT lane2;
    redirectT   redirect;

    logic [31:0] vecMem [0:numVectors*wordsPerVector-1];
    int          errorCount;
    int          cycleCount;

    executeStage uut (
        .clk_i      (clk),
        .rstN_i     (rstN),
        .issue1_i   (issue1),
        .issue2_i   (issue2),
        .fwd_i      (fwd),
        .lane1_o    (lane1),
        .lane2_o    (lane2),
        .redirect_o (redirect)
    );

    always #2 clk = !clk;

    // ####################
    // Vector decoding
    // ####################

    // One nibble per field, the last one holds srcAIsPc, srcBIsImm and predictTaken
    function automatic issueSlotT decodeSlot(
        input logic [31:0] ctrl,
        input logic [31:0] pc,
        input logic [31:0] imm,
        input logic [31:0] rs1,
        input logic [31:0] rs2
    );
        issueSlotT slot;
        slot.valid        = ctrl[28];
        slot.aluOp        = aluOpE'(ctrl[27:24]);
        slot.jumpKind     = jumpKindE'(ctrl[21:20]);
        slot.branch       = ctrl[16];
        slot.branchType   = branchTypeE'(ctrl[14:12]);
        slot.fwdA         = fwdSelE'(ctrl[10:8]);
        slot.fwdB         = fwdSelE'(ctrl[6:4]);
        slot.srcAIsPc     = ctrl[2];
        slot.srcBIsImm    = ctrl[1];
        slot.predictTaken = ctrl[0];
        slot.pc           = pc;
        slot.imm          = imm;
        slot.rs1Data      = rs1;
        slot.rs2Data      = rs2;
        return slot;
    endfunction

    task automatic driveSlots(input int k);
        int base;
        base   = k * wordsPerVector;
        issue1 = decodeSlot(vecMem[base], vecMem[base+1], vecMem[base+2],
                            vecMem[base+3], vecMem[base+4]);
        issue2 = decodeSlot(vecMem[base+5], vecMem[base+6], vecMem[base+7],
                            vecMem[base+8], vecMem[base+9]);
    endtask

    task automatic driveFwd(input int k);
        int base;
        base            = k * wordsPerVector;
        fwd.aluResultM1 = vecMem[base+10];
        fwd.aluResultM2 = vecMem[base+11];
        fwd.resultW1    = vecMem[base+12];
        fwd.resultW2    = vecMem[base+13];
    endtask

    // ####################
    // Checks
    // ####################

    task automatic compareValue(
        input string       where,
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        assert (actual === expected)
        else begin
            $display("Error at time %0t: %s %s expected %h, got %h",
                     $time, where, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkIdle();
        compareValue("idle", "lane1_o.valid", {31'd0, lane1.valid}, 32'd0);
        compareValue("idle", "lane2_o.valid", {31'd0, lane2.valid}, 32'd0);
        compareValue("idle", "redirect_o.redirect", {31'd0, redirect.redirect}, 32'd0);
        compareValue("idle", "redirect_o.targetPc", redirect.targetPc, 32'd0);
    endtask

    task automatic checkOutputs(input int k);
        int          base;
        string       where;
        logic [31:0] flags;
        base  = k * wordsPerVector;
        where = $sformatf("vector %0d", k);
        flags = vecMem[base+14];
        compareValue(where, "lane1_o.valid", {31'd0, lane1.valid}, {31'd0, flags[16]});
        compareValue(where, "lane2_o.valid", {31'd0, lane2.valid}, {31'd0, flags[12]});
        compareValue(where, "redirect_o.redirect", {31'd0, redirect.redirect},
                     {31'd0, flags[8]});
        compareValue(where, "redirect_o.isBranch", {31'd0, redirect.isBranch},
                     {31'd0, flags[4]});
        compareValue(where, "redirect_o.taken", {31'd0, redirect.taken}, {31'd0, flags[0]});
        compareValue(where, "lane1_o.result", lane1.result, vecMem[base+15]);
        compareValue(where, "lane1_o.writeData", lane1.writeData, vecMem[base+16]);
        compareValue(where, "lane2_o.result", lane2.result, vecMem[base+17]);
        compareValue(where, "lane2_o.writeData", lane2.writeData, vecMem[base+18]);
        compareValue(where, "redirect_o.targetPc", redirect.targetPc, vecMem[base+19]);
    endtask

    // ####################
    // Stimulus
    // ####################

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        issue1     = '0;
        issue2     = '0;
        fwd        = '0;
        errorCount = 0;
        cycleCount = 0;

        $readmemh("dv/executeStageTests.mem", vecMem);

        // Every vector has a valid lane 1, so a clear bit here means the file ran short
        if (vecMem[(numVectors - 1) * wordsPerVector][28] !== 1'b1) begin
            $display("The test vector file is missing or holds fewer than %0d vectors",
                     numVectors);
            errorCount++;
        end

        repeat (resetCycles) begin
            @(negedge clk);
            checkIdle();
        end
        rstN = 1'b1;

        // Slots of vector t go in with the forwarding values of vector t-1
        for (int t = 0; t < numVectors + 2; t++) begin
            @(negedge clk);
            if (t < 2) begin
                checkIdle();
            end else begin
                checkOutputs(t - 2);
            end
            if (t < numVectors) begin
                driveSlots(t);
            end else begin
                issue1 = '0;
                issue2 = '0;
            end
            if (t >= 1 && t <= numVectors) begin
                driveFwd(t - 1);
            end else begin
                fwd = '0;
            end
        end

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("The run timed out after %0d cycles", cycleLimit);
            $display("Errors: %0d", errorCount + 1);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/executeStageTests.mem */
// c1 pc1 imm1 rs1 rs2 c2 pc2 imm2 rs1 rs2 m1 m2 w1 w2 flags res1 wd1 res2 wd2 target
// c nibbles: valid op jump branch brType fwdA fwdB {aIsPc bIsImm pred}; flags: v1 v2 rd isBr tk
10000000 100 0 5 7 11000000 104 0 3 5 0 0 0 0 11000 c 7 fffffffe 5 0
12000002 108 ff00 f0f0 1 13000000 10c 0 f0f0 f0f 0 0 0 0 11000 f000 1 ffff f0f 0
14000002 110 f0f ff 2 15000000 114 0 3 24 0 0 0 0 11000 ff0 2 30 24 0
16000002 118 4 80000000 0 17000000 11c 0 80000000 4 0 0 0 0 11000 8000000 0 f8000000 4 0
18000000 120 0 fffffffe 1 19000000 124 0 fffffffe 1 0 0 0 0 11000 1 1 0 1 0
1a000002 128 12345000 0 0 10000006 12c 1000 9 3 0 0 0 0 11000 12345000 0 112c 3 0
10000120 130 0 1 2 10000340 134 0 1 2 a1 b2 c3 d4 11000 153 b2 197 d4 0
10000412 138 8 5 6 14000230 13c 0 7 8 1000 2000 3000 4000 11000 4008 1000 1000 3000 0
11010001 200 40 5 5 11010001 204 20 5 6 0 0 0 0 11110 0 5 ffffffff 6 208
11010000 210 40 7 9 11010000 214 fffffff0 9 9 0 0 0 0 11111 fffffffe 9 0 9 204
11011001 220 10 3 4 11011001 224 10 4 4 0 0 0 0 11110 ffffffff 4 0 4 228
11011000 230 10 8 8 11011000 234 30 8 1 0 0 0 0 11111 0 8 7 1 264
11014001 240 20 fffffffe 1 11014001 244 20 1 fffffffe 0 0 0 0 11110 fffffffd 1 3 fffffffe 248
11014000 250 20 5 5 11014000 254 8 80000000 7fffffff 0 0 0 0 11111 0 5 1 7fffffff 25c
11015001 260 40 6 6 11015001 264 40 ffffffff 0 0 0 0 0 11110 0 6 ffffffff 0 268
11015000 270 40 2 3 11015000 274 ffffffe0 3 fffffffd 0 0 0 0 11111 ffffffff 3 6 fffffffd 254
19016001 280 10 1 ffffffff 19016001 284 10 ffffffff 1 0 0 0 0 11110 1 ffffffff 0 1 288
19016000 290 10 4 4 19016000 294 100 2 3 0 0 0 0 11111 0 4 1 3 394
19017001 2a0 20 80000000 1 19017001 2a4 20 1 80000000 0 0 0 0 11110 0 1 1 80000000 2a8
19017000 2b0 20 0 1 19017000 2b4 4c 9 9 0 0 0 0 11111 1 1 0 9 300
10200002 300 10 1001 0 10000000 304 0 1 2 0 0 0 0 10100 304 0 3 2 1010
10000000 310 0 2 3 10100006 314 100 0 0 0 0 0 0 11100 5 3 318 0 414
10100006 320 ffffff00 0 0 11010000 324 40 1 1 0 0 0 0 10100 324 0 0 1 220
11011001 330 40 5 5 10200002 334 3 500 0 0 0 0 0 10110 0 5 338 0 334
11010000 340 8 1 2 11011001 344 8 1 2 0 0 0 0 11010 ffffffff 2 ffffffff 2 0

/* hw/alu.sv */
`default_nettype none

module alu (
    input  logic [31:0]  srcA_i,
    input  logic [31:0]  srcB_i,
    input  exPkg::aluOpE op_i,
    output logic [31:0]  result_o,
    output logic         zero_o,
    output logic         less_o
);
    import exPkg::*;

    logic [32:0] diff;
    logic        signedLess;
    logic        unsignedLess;
    logic [4:0]  shamt;

    // One subtractor serves SUB, SLT, SLTU and the branch compares
    assign diff = {1'b0, srcA_i} - {1'b0, srcB_i};

    // The borrow out of the 33-bit difference is the unsigned compare
    assign unsignedLess = diff[32];

    // With differing signs the negative operand is the smaller one
    assign signedLess = (srcA_i[31] != srcB_i[31]) ? srcA_i[31] : diff[31];

    assign shamt = srcB_i[4:0];

    always_comb begin
        case (op_i)
            ADD:     result_o = srcA_i + srcB_i;
            SUB:     result_o = diff[31:0];
            AND:     result_o = srcA_i & srcB_i;
            OR:      result_o = srcA_i | srcB_i;
            XOR:     result_o = srcA_i ^ srcB_i;
            SLL:     result_o = srcA_i << shamt;
            SRL:     result_o = srcA_i >> shamt;
            SRA:     result_o = $unsigned($signed(srcA_i) >>> shamt);
            SLT:     result_o = {31'd0, signedLess};
            SLTU:    result_o = {31'd0, unsignedLess};
            PASSB:   result_o = srcB_i;
            default: result_o = 32'd0;
        endcase
    end

    assign zero_o = (result_o == 32'd0);

    // BLTU and BGEU are decoded to SLTU, the other branches to SUB
    assign less_o = (op_i == SLTU) ? unsignedLess : signedLess;

    always_comb begin
        assert final (!$isunknown(op_i))
            else $error("alu: operation select is unknown");
    end

endmodule

`default_nettype wire

/* hw/branchResolve.sv */
`default_nettype none

module branchResolve (
    input  exPkg::jumpKindE   jumpKind_i,
    input  logic              branch_i,
    input  exPkg::branchTypeE branchType_i,
    input  logic              zero_i,
    input  logic              less_i,
    output exPkg::pcSrcE      pcSrc_o,
    output logic              taken_o
);
    import exPkg::*;

    logic condMet;

    // Signedness is already folded into less_i by the ALU
    always_comb begin
        case (branchType_i)
            BEQ:       condMet = zero_i;
            BNE:       condMet = !zero_i;
            BLT, BLTU: condMet = less_i;
            BGE, BGEU: condMet = !less_i;
            default:   condMet = 1'b0;
        endcase
    end

    assign taken_o = branch_i && condMet;

    always_comb begin
        case (jumpKind_i)
            JAL:     pcSrc_o = TARGET;
            JALR:    pcSrc_o = ALU;
            default: pcSrc_o = taken_o ? TARGET : SEQ;
        endcase
    end

    always_comb begin
        assert final (!(branch_i && (jumpKind_i != NONE)))
            else $error("branchResolve: branch and jump decoded together");
    end

endmodule

`default_nettype wire

/* hw/exPkg.sv */
`default_nettype none

package exPkg;

    // ####################
    // Encodings
    // ####################

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        SLT   = 4'd8,
        SLTU  = 4'd9,
        PASSB = 4'd10
    } aluOpE;

    // Values follow the RV32I funct3 field of the branch instructions
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } branchTypeE;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        JAL  = 2'd1,
        JALR = 2'd2
    } jumpKindE;

    typedef enum logic [1:0] {
        SEQ    = 2'd0,
        TARGET = 2'd1,
        ALU    = 2'd2
    } pcSrcE;

    typedef enum logic [2:0] {
        REG = 3'd0,
        M1  = 3'd1,
        M2  = 3'd2,
        W1  = 3'd3,
        W2  = 3'd4
    } fwdSelE;

    // ####################
    // Lane structs
    // ####################

    typedef struct packed {
        logic        valid;
        aluOpE       aluOp;
        jumpKindE    jumpKind;
        logic        branch;
        branchTypeE  branchType;
        logic        srcAIsPc;
        logic        srcBIsImm;
        fwdSelE      fwdA;
        fwdSelE      fwdB;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1Data;
        logic [31:0] rs2Data;
        logic        predictTaken;
    } issueSlotT;

    typedef struct packed {
        logic [31:0] aluResultM1;
        logic [31:0] aluResultM2;
        logic [31:0] resultW1;
        logic [31:0] resultW2;
    } fwdBusT;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] writeData;
    } laneResultT;

    // isBranch and taken feed the branch predictor update
    typedef struct packed {
        logic        redirect;
        logic [31:0] targetPc;
        logic        isBranch;
        logic        taken;
    } redirectT;

endpackage

`default_nettype wire

/* hw/execute.sv */
`default_nettype none

module execute (
    input  exPkg::issueSlotT  issue1_i,
    input  exPkg::issueSlotT  issue2_i,
    input  exPkg::fwdBusT     fwd_i,
    output exPkg::laneResultT lane1_o,
    output exPkg::laneResultT lane2_o,
    output exPkg::redirectT   redirect_o
);
    import exPkg::*;

    // Index 0 is lane 1 (older), index 1 is lane 2
    issueSlotT   slot         [2];
    logic [31:0] srcA         [2];
    logic [31:0] srcB         [2];
    logic [31:0] writeData    [2];
    logic [31:0] aluResult    [2];
    logic        aluZero      [2];
    logic        aluLess      [2];
    pcSrcE       pcSrc        [2];
    logic        brTaken      [2];
    logic [31:0] branchTarget [2];
    logic [31:0] linkPc       [2];
    logic [31:0] laneTarget   [2];
    logic        isBranch     [2];
    logic        isJump       [2];
    logic        laneRedirect [2];
    laneResultT  laneRes      [2];
    logic        sel;

    assign slot[0] = issue1_i;
    assign slot[1] = issue2_i;

    // ####################
    // Per-lane datapath
    // ####################

    for (genvar i = 0; i < 2; i++) begin : gLane
        operandSelect uOperandSelect (
            .slot_i      (slot[i]),
            .fwd_i       (fwd_i),
            .srcA_o      (srcA[i]),
            .srcB_o      (srcB[i]),
            .writeData_o (writeData[i])
        );

        alu uAlu (
            .srcA_i   (srcA[i]),
            .srcB_i   (srcB[i]),
            .op_i     (slot[i].aluOp),
            .result_o (aluResult[i]),
            .zero_o   (aluZero[i]),
            .less_o   (aluLess[i])
        );

        branchResolve uBranchResolve (
            .jumpKind_i   (slot[i].jumpKind),
            .branch_i     (slot[i].branch),
            .branchType_i (slot[i].branchType),
            .zero_i       (aluZero[i]),
            .less_i       (aluLess[i]),
            .pcSrc_o      (pcSrc[i]),
            .taken_o      (brTaken[i])
        );

        assign branchTarget[i] = slot[i].pc + slot[i].imm;
        assign linkPc[i]       = slot[i].pc + 32'd4;

        // A not-taken mispredict falls through to PC plus 4
        assign laneTarget[i] = (pcSrc[i] == TARGET) ? branchTarget[i] :
                               (pcSrc[i] == ALU)    ? {aluResult[i][31:1], 1'b0} :
                                                      linkPc[i];

        assign isBranch[i] = slot[i].valid && slot[i].branch;
        assign isJump[i]   = slot[i].valid && (slot[i].jumpKind != NONE);

        assign laneRedirect[i] = isJump[i] ||
                                 (isBranch[i] && (brTaken[i] != slot[i].predictTaken));

        assign laneRes[i] = '{
            valid:     slot[i].valid,
            result:    (slot[i].jumpKind != NONE) ? linkPc[i] : aluResult[i],
            writeData: writeData[i]
        };
    end

    // ####################
    // Redirect and squash
    // ####################

    // Lane 2 reports when lane 1 stays quiet and lane 2 redirects or lane 1 holds no branch
    assign sel = !laneRedirect[0] && (laneRedirect[1] || !isBranch[0]);

    assign lane1_o = laneRes[0];

    always_comb begin
        lane2_o = laneRes[1];
        if (laneRedirect[0]) begin
            lane2_o.valid = 1'b0;
        end
    end

    always_comb begin
        redirect_o.redirect = laneRedirect[sel];
        redirect_o.targetPc = laneRedirect[sel] ? laneTarget[sel] : 32'd0;
        redirect_o.isBranch = isBranch[sel];
        redirect_o.taken    = isBranch[sel] && brTaken[sel];
    end

    always_comb begin
        assert final (!redirect_o.redirect || isJump[sel] ||
                      (redirect_o.isBranch &&
                       (redirect_o.targetPc ==
                        (redirect_o.taken ? branchTarget[sel] : linkPc[sel]))))
            else $error("execute: branch redirect without isBranch or to the wrong target");
    end

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  exPkg::issueSlotT  issue1_i,
    input  exPkg::issueSlotT  issue2_i,
    input  exPkg::fwdBusT     fwd_i,
    output exPkg::laneResultT lane1_o,
    output exPkg::laneResultT lane2_o,
    output exPkg::redirectT   redirect_o
);
    import exPkg::*;

    issueSlotT  issue1Q;
    issueSlotT  issue2Q;
    laneResultT lane1D;
    laneResultT lane2D;
    redirectT   redirectD;

    // ####################
    // ID/EX register
    // ####################

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            issue1Q <= '0;
            issue2Q <= '0;
        end else begin
            issue1Q <= issue1_i;
            issue2Q <= issue2_i;
        end
    end

    // The forwarding bus belongs to the execute cycle and bypasses ID/EX
    execute uExecute (
        .issue1_i   (issue1Q),
        .issue2_i   (issue2Q),
        .fwd_i      (fwd_i),
        .lane1_o    (lane1D),
        .lane2_o    (lane2D),
        .redirect_o (redirectD)
    );

    // ####################
    // EX/MEM register
    // ####################

    // Lane 2 arrives here already squashed when lane 1 redirected
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            lane1_o    <= '0;
            lane2_o    <= '0;
            redirect_o <= '0;
        end else begin
            lane1_o    <= lane1D;
            lane2_o    <= lane2D;
            redirect_o <= redirectD;
        end
    end

    // A jump held in lane 1 shows up one cycle later as a redirect with lane 2 dropped
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        $past(issue1Q.valid && (issue1Q.jumpKind != NONE))
            |-> (redirect_o.redirect && !lane2_o.valid))
        else $error("executeStage: lane 2 survived a lane 1 redirect");

endmodule

`default_nettype wire

/* hw/operandSelect.sv */
`default_nettype none

module operandSelect (
    input  exPkg::issueSlotT slot_i,
    input  exPkg::fwdBusT    fwd_i,
    output logic [31:0]      srcA_o,
    output logic [31:0]      srcB_o,
    output logic [31:0]      writeData_o
);
    import exPkg::*;

    logic [31:0] fwdValA;
    logic [31:0] fwdValB;

    function automatic logic [31:0] pickOperand(
        input fwdSelE      sel,
        input logic [31:0] regVal,
        input fwdBusT      bus
    );
        logic [31:0] value;
        case (sel)
            M1:      value = bus.aluResultM1;
            M2:      value = bus.aluResultM2;
            W1:      value = bus.resultW1;
            W2:      value = bus.resultW2;
            default: value = regVal;
        endcase
        return value;
    endfunction

    assign fwdValA = pickOperand(slot_i.fwdA, slot_i.rs1Data, fwd_i);
    assign fwdValB = pickOperand(slot_i.fwdB, slot_i.rs2Data, fwd_i);

    assign srcA_o = slot_i.srcAIsPc ? slot_i.pc : fwdValA;
    assign srcB_o = slot_i.srcBIsImm ? slot_i.imm : fwdValB;

    // Stores write the forwarded rs2 even though B carries the offset
    assign writeData_o = fwdValB;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module executeStageTb -o executeStageSim

./obj_dir/executeStageSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

/* src.f */
hw/exPkg.sv
hw/alu.sv
hw/operandSelect.sv
hw/branchResolve.sv
hw/execute.sv
hw/executeStage.sv
dv/executeStageTb.sv
